/* design/video_pkg.sv */
package video_pkg;

  //////////////////////////////
  // color widths
  //////////////////////////////

  localparam int COLOR_W_IN  = 7;  // console side
  localparam int COLOR_W_OUT = 8;  // after expansion

  //////////////////////////////
  // datapath types
  //////////////////////////////

  typedef logic [COLOR_W_IN-1:0]  color_in_t;
  typedef logic [COLOR_W_OUT-1:0] color_out_t;

  // stored pixel, red in the upper bits, blue in the lower
  typedef logic [3*COLOR_W_IN-1:0] pixel_t;

endpackage

/* design/linemult_pkg.sv */
package linemult_pkg;

  //////////////////////////////
  // buffer geometry
  //////////////////////////////

  localparam int PAGE_CNT  = 4;   // lines held in the buffer
  localparam int BUF_DEPTH = 64;  // pixels per page

  typedef logic [$clog2(PAGE_CNT)-1:0]  page_t;
  typedef logic [$clog2(BUF_DEPTH)-1:0] buf_addr_t;

  //////////////////////////////
  // line timing
  //////////////////////////////

  // strobes on the input side, clocks on the output side
  typedef logic [7:0] hcnt_t;

  localparam hcnt_t LINE_LEN_MAX = 8'd200;  // longer lines are dropped
  localparam hcnt_t HSTART       = 8'd8;    // first active position
  localparam hcnt_t HSTOP        = 8'd56;   // first position past active
  localparam hcnt_t HS_WIDTH     = 8'd6;    // output hsync pulse

  //////////////////////////////
  // scanlines and reader
  //////////////////////////////

  typedef logic [7:0] sl_str_t;

  typedef enum logic [1:0] {
    RD_IDLE  = 2'd0,
    RD_COPY0 = 2'd1,  // first playback of the line
    RD_COPY1 = 2'd2   // second playback
  } rd_state_t;

endpackage

/* design/linemult_if.sv */
`timescale 1ns/1ns

// write port of the line buffer
interface buf_wr_if import video_pkg::*, linemult_pkg::*; ();

  logic      wren;
  page_t     page;
  buf_addr_t addr;
  pixel_t    data;

  modport writer (output wren, page, addr, data);
  modport mem    (input  wren, page, addr, data);

endinterface

// read port, data comes back one clock after rden
interface buf_rd_if import video_pkg::*, linemult_pkg::*; ();

  logic      rden;
  page_t     page;
  buf_addr_t addr;
  pixel_t    data;

  modport reader (output rden, page, addr, input  data);
  modport mem    (input  rden, page, addr, output data);

endinterface

// completed line announcement, no handshake back
interface line_done_if import linemult_pkg::*; ();

  logic  done;    // single clock pulse
  page_t page;
  hcnt_t len;     // in strobes
  logic  nvsync;  // vsync level at line start

  modport src (output done, page, len, nvsync);
  modport dst (input  done, page, len, nvsync);

endinterface

/* design/line_writer.sv */
`timescale 1ns/1ns

module line_writer import video_pkg::*, linemult_pkg::*; (
  input  logic     VCLK_o,
  input  logic     nVRST_o,
  input  logic     vdata_valid_i,
  input  logic     nhsync_i,
  input  logic     nvsync_i,
  input  pixel_t   pixel_i,
  buf_wr_if.writer wr,
  line_done_if.src ld
);

  logic  hs_prev;     // hsync level at previous strobe
  hcnt_t wr_cnt;      // strobes so far in this line
  page_t wr_page;
  logic  line_vs;     // vsync sampled at position 0
  logic  line_start;
  logic  len_ok;
  hcnt_t wr_pos;
  hcnt_t wr_off;
  logic  wr_act;

  assign line_start = vdata_valid_i & hs_prev & ~nhsync_i;  // falling hsync on a strobe
  assign len_ok     = (wr_cnt <= LINE_LEN_MAX);
  assign wr_pos     = line_start ? '0 : wr_cnt;
  assign wr_off     = wr_pos - HSTART;
  assign wr_act     = vdata_valid_i && (wr_pos >= HSTART) && (wr_pos < HSTOP);

  //////////////////////////////
  // line counting
  //////////////////////////////

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      hs_prev <= 1'b1;
      wr_cnt  <= LINE_LEN_MAX + 8'd1;  // treat the partial line before sync as overlong
      wr_page <= '0;
      ld.done <= 1'b0;
      wr.wren <= 1'b0;
    end else begin
      ld.done <= line_start & len_ok;  // announce the line that just ended
      wr.wren <= wr_act;
      if (vdata_valid_i) begin
        hs_prev <= nhsync_i;
        if (line_start) begin
          wr_cnt <= 8'd1;
          if (len_ok)
            wr_page <= wr_page + 2'd1;  // dropped lines reuse their page
        end else if (len_ok) begin
          wr_cnt <= wr_cnt + 8'd1;  // stops one past the limit
        end
      end
    end
  end

  //////////////////////////////
  // payload
  //////////////////////////////

  always_ff @(posedge VCLK_o) begin
    if (line_start) begin
      line_vs   <= nvsync_i;
      ld.page   <= wr_page;
      ld.len    <= wr_cnt;
      ld.nvsync <= line_vs;  // flag of the finished line
    end
    wr.page <= wr_page;
    wr.addr <= buf_addr_t'(wr_off);
    wr.data <= pixel_i;
  end

  a_wr_addr_range: assert property (
    @(posedge VCLK_o) disable iff (!nVRST_o)
    wr_act |-> (wr_off < BUF_DEPTH)
  );

endmodule

/* design/line_buffer.sv */
`timescale 1ns/1ns

module line_buffer import video_pkg::*, linemult_pkg::*; (
  input  logic  VCLK_o,
  buf_wr_if.mem wr,
  buf_rd_if.mem rd
);

  pixel_t mem [PAGE_CNT][BUF_DEPTH];

  //////////////////////////////
  // write port
  //////////////////////////////

  always_ff @(posedge VCLK_o) begin
    if (wr.wren)
      mem[wr.page][wr.addr] <= wr.data;
  end

  //////////////////////////////
  // read port
  //////////////////////////////

  // one clock of latency, data holds between reads
  always_ff @(posedge VCLK_o) begin
    if (rd.rden)
      rd.data <= mem[rd.page][rd.addr];
  end

  // writer always runs at least one page ahead of the reader
  a_no_page_clash: assert property (
    @(posedge VCLK_o)
    !(wr.wren && rd.rden && (wr.page == rd.page))
  );

endmodule

/* design/line_reader.sv */
`timescale 1ns/1ns

module line_reader import linemult_pkg::*; (
  input  logic     VCLK_o,
  input  logic     nVRST_o,
  line_done_if.dst ld,
  buf_rd_if.reader rd,
  input  logic     sl_en_i,
  input  logic     sl_id_i,
  input  sl_str_t  sl_str_i,
  output logic     act_o,
  output logic     copy_o,
  output logic     nhs_o,
  output logic     nvs_o,
  output logic     vld_o,
  output logic     sl_en_o,
  output logic     sl_id_o,
  output sl_str_t  sl_str_o
);

  rd_state_t state;
  hcnt_t     pos;        // output position within a copy

  page_t     cur_page;
  hcnt_t     cur_len;
  logic      cur_vs;

  logic      pend_vld;   // one announcement waiting
  page_t     pend_page;
  hcnt_t     pend_len;
  logic      pend_vs;

  logic      sl_en_q;
  logic      sl_id_q;
  sl_str_t   sl_str_q;

  logic      busy;
  logic      copy_end;
  logic      pair_end;
  logic      start_pair;
  logic      rd_act;

  assign busy       = (state != RD_IDLE);
  assign copy_end   = busy && (pos == cur_len - 8'd1);
  assign pair_end   = (state == RD_COPY1) && copy_end;
  assign start_pair = ((state == RD_IDLE) && ld.done) || (pair_end && (pend_vld || ld.done));

  // active window of the stored line
  assign rd_act  = busy && (pos >= HSTART) && (pos < HSTOP) && (pos < cur_len);
  assign rd.rden = rd_act;
  assign rd.page = cur_page;
  assign rd.addr = buf_addr_t'(pos - HSTART);

  //////////////////////////////
  // playback FSM
  //////////////////////////////

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      state    <= RD_IDLE;
      pos      <= '0;
      pend_vld <= 1'b0;
      act_o    <= 1'b0;
      copy_o   <= 1'b0;
      nhs_o    <= 1'b1;
      nvs_o    <= 1'b1;
      vld_o    <= 1'b0;
    end else begin
      case (state)
        RD_IDLE:  if (start_pair) state <= RD_COPY0;
        RD_COPY0: if (copy_end) state <= RD_COPY1;
        RD_COPY1: if (copy_end) state <= start_pair ? RD_COPY0 : RD_IDLE;
        default:  state <= RD_IDLE;
      endcase
      pos <= (copy_end || !busy) ? '0 : pos + 8'd1;

      if (start_pair && pend_vld)
        pend_vld <= 1'b0;   // pending line consumed
      if (ld.done && !(start_pair && !pend_vld))
        pend_vld <= 1'b1;   // arrived while busy

      // aligned with buffer data
      act_o  <= rd_act;
      copy_o <= (state == RD_COPY1);
      nhs_o  <= !(busy && (pos < HS_WIDTH));
      nvs_o  <= busy ? cur_vs : 1'b1;
      vld_o  <= busy;
    end
  end

  //////////////////////////////
  // line and setting latches
  //////////////////////////////

  always_ff @(posedge VCLK_o) begin
    if (start_pair) begin
      cur_page <= pend_vld ? pend_page : ld.page;
      cur_len  <= pend_vld ? pend_len  : ld.len;
      cur_vs   <= pend_vld ? pend_vs   : ld.nvsync;
      sl_en_q  <= sl_en_i;  // fixed for the whole pair
      sl_id_q  <= sl_id_i;
      sl_str_q <= sl_str_i;
    end
    if (ld.done) begin
      pend_page <= ld.page;
      pend_len  <= ld.len;
      pend_vs   <= ld.nvsync;
    end
    sl_en_o  <= sl_en_q;  // keeps the last pixel of a pair on its own settings
    sl_id_o  <= sl_id_q;
    sl_str_o <= sl_str_q;
  end

  a_no_idle_pending: assert property (
    @(posedge VCLK_o) disable iff (!nVRST_o)
    (state == RD_IDLE) |-> !pend_vld
  );

endmodule

/* design/scanline_gen.sv */
`timescale 1ns/1ns

module scanline_gen import video_pkg::*, linemult_pkg::*; (
  input  logic       VCLK_o,
  input  logic       nVRST_o,
  input  logic       act_i,
  input  logic       copy_i,
  input  logic       nhs_i,
  input  logic       nvs_i,
  input  logic       vld_i,
  input  pixel_t     pixel_i,
  input  logic       sl_en_i,
  input  logic       sl_id_i,
  input  sl_str_t    sl_str_i,
  output logic       vdata_valid_o,
  output logic       nhsync_o,
  output logic       nvsync_o,
  output color_out_t r_o,
  output color_out_t g_o,
  output color_out_t b_o
);

  // expand one channel and darken it when asked
  function automatic color_out_t shade(color_in_t c, logic dark, sl_str_t str);
    color_out_t               ce;
    sl_str_t                  gain;
    logic [2*COLOR_W_OUT-1:0] prod;
    ce   = {c, c[COLOR_W_IN-1]};  // msb repeated below lsb
    gain = 8'd255 - str;
    prod = ce * gain;
    return dark ? prod[2*COLOR_W_OUT-1:COLOR_W_OUT] : ce;
  endfunction

  color_in_t  r_in;
  color_in_t  g_in;
  color_in_t  b_in;
  logic       dark;
  color_out_t r_s;
  color_out_t g_s;
  color_out_t b_s;
  logic       nhs_s;
  logic       nvs_s;
  logic       vld_s;

  assign r_in = pixel_i[3*COLOR_W_IN-1 -: COLOR_W_IN];
  assign g_in = pixel_i[2*COLOR_W_IN-1 -: COLOR_W_IN];
  assign b_in = pixel_i[COLOR_W_IN-1:0];
  assign dark = sl_en_i && (copy_i == sl_id_i);

  //////////////////////////////
  // scanline stage
  //////////////////////////////

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      r_s   <= '0;
      g_s   <= '0;
      b_s   <= '0;
      nhs_s <= 1'b1;
      nvs_s <= 1'b1;
      vld_s <= 1'b0;
    end else begin
      r_s   <= act_i ? shade(r_in, dark, sl_str_i) : '0;  // black outside active
      g_s   <= act_i ? shade(g_in, dark, sl_str_i) : '0;
      b_s   <= act_i ? shade(b_in, dark, sl_str_i) : '0;
      nhs_s <= nhs_i;
      nvs_s <= nvs_i;
      vld_s <= vld_i;
    end
  end

  //////////////////////////////
  // output register
  //////////////////////////////

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      r_o           <= '0;
      g_o           <= '0;
      b_o           <= '0;
      nhsync_o      <= 1'b1;
      nvsync_o      <= 1'b1;
      vdata_valid_o <= 1'b0;
    end else begin
      r_o           <= r_s;
      g_o           <= g_s;
      b_o           <= b_s;
      nhsync_o      <= nhs_s;
      nvsync_o      <= nvs_s;
      vdata_valid_o <= vld_s;
    end
  end

endmodule

/* design/linemult_top.sv */
`timescale 1ns/1ns

module linemult_top import video_pkg::*, linemult_pkg::*; (
  input  logic       VCLK_o,
  input  logic       nVRST_o,
  input  logic       vdata_valid_i,  // one strobe every second clock
  input  logic       nhsync_i,
  input  logic       nvsync_i,
  input  color_in_t  r_i,
  input  color_in_t  g_i,
  input  color_in_t  b_i,
  input  logic       sl_en_i,
  input  logic       sl_id_i,
  input  sl_str_t    sl_str_i,
  output logic       vdata_valid_o,
  output logic       nhsync_o,
  output logic       nvsync_o,
  output color_out_t r_o,
  output color_out_t g_o,
  output color_out_t b_o
);

  pixel_t  pixel_in;
  logic    act;
  logic    copy;
  logic    nhs;
  logic    nvs;
  logic    vld;
  logic    sl_en;
  logic    sl_id;
  sl_str_t sl_str;

  assign pixel_in = {r_i, g_i, b_i};

  buf_wr_if    u_wr_if ();
  buf_rd_if    u_rd_if ();
  line_done_if u_ld_if ();

  //////////////////////////////
  // input side
  //////////////////////////////

  line_writer u_writer (
    .VCLK_o        (VCLK_o),
    .nVRST_o       (nVRST_o),
    .vdata_valid_i (vdata_valid_i),
    .nhsync_i      (nhsync_i),
    .nvsync_i      (nvsync_i),
    .pixel_i       (pixel_in),
    .wr            (u_wr_if.writer),
    .ld            (u_ld_if.src)
  );

  line_buffer u_buffer (
    .VCLK_o (VCLK_o),
    .wr     (u_wr_if.mem),
    .rd     (u_rd_if.mem)
  );

  //////////////////////////////
  // output side
  //////////////////////////////

  line_reader u_reader (
    .VCLK_o   (VCLK_o),
    .nVRST_o  (nVRST_o),
    .ld       (u_ld_if.dst),
    .rd       (u_rd_if.reader),
    .sl_en_i  (sl_en_i),
    .sl_id_i  (sl_id_i),
    .sl_str_i (sl_str_i),
    .act_o    (act),
    .copy_o   (copy),
    .nhs_o    (nhs),
    .nvs_o    (nvs),
    .vld_o    (vld),
    .sl_en_o  (sl_en),
    .sl_id_o  (sl_id),
    .sl_str_o (sl_str)
  );

  scanline_gen u_scanline (
    .VCLK_o        (VCLK_o),
    .nVRST_o       (nVRST_o),
    .act_i         (act),
    .copy_i        (copy),
    .nhs_i         (nhs),
    .nvs_i         (nvs),
    .vld_i         (vld),
    .pixel_i       (u_rd_if.data),  // buffer read data
    .sl_en_i       (sl_en),
    .sl_id_i       (sl_id),
    .sl_str_i      (sl_str),
    .vdata_valid_o (vdata_valid_o),
    .nhsync_o      (nhsync_o),
    .nvsync_o      (nvsync_o),
    .r_o           (r_o),
    .g_o           (g_o),
    .b_o           (b_o)
  );

endmodule

/* bench/tb_linemult.sv */
`timescale 1ns/1ns

module tb_linemult import video_pkg::*, linemult_pkg::*; ();

  localparam int CLK_PERIOD  = 20;
  localparam int IN_HS_WIDTH = 4;   // input hsync length in strobes
  localparam int MAX_REC     = 32;
  localparam int MAX_LINES   = 32;

  logic       VCLK_o;
  logic       nVRST_o;
  logic       vdata_valid_i;
  logic       nhsync_i;
  logic       nvsync_i;
  color_in_t  r_i;
  color_in_t  g_i;
  color_in_t  b_i;
  logic       sl_en_i;
  logic       sl_id_i;
  sl_str_t    sl_str_i;
  logic       vdata_valid_o;
  logic       nhsync_o;
  logic       nvsync_o;
  color_out_t r_o;
  color_out_t g_o;
  color_out_t b_o;

  // pattern records
  int        rec_len [MAX_REC];
  logic      rec_vs  [MAX_REC];
  logic      rec_en  [MAX_REC];
  logic      rec_id  [MAX_REC];
  sl_str_t   rec_str [MAX_REC];
  int        num_rec = 0;
  int        total_strobes = 0;
  int        exp_accept = 0;     // records within the length limit
  logic      load_ok;
  logic      patterns_loaded = 1'b0;
  logic [15:0] lfsr_state;

  // reference model state
  int        cyc = 0;
  int        line_cnt = 0;
  int        ann_cnt = 0;        // accepted input lines
  int        start_cnt = 0;      // lines whose playback has begun
  int        free_edge = 0;
  logic      model_hs_prev = 1'b1;
  logic      model_in_line = 1'b0;
  logic      backlog_seen = 1'b0;
  int        ann_edge   [MAX_LINES];
  hcnt_t     exp_len    [MAX_LINES];
  logic      exp_vs     [MAX_LINES];
  logic      exp_sl_en  [MAX_LINES];
  logic      exp_sl_id  [MAX_LINES];
  sl_str_t   exp_sl_str [MAX_LINES];
  color_in_t exp_r [MAX_LINES][BUF_DEPTH];
  color_in_t exp_g [MAX_LINES][BUF_DEPTH];
  color_in_t exp_b [MAX_LINES][BUF_DEPTH];

  // monitor state
  int        out_lines = 0;
  int        out_pos = 0;
  logic      in_out = 1'b0;
  logic      mon_nhs_prev = 1'b1;
  logic      stray_seen = 1'b0;
  int        extra_reported = -1;

  int        err_color = 0;
  int        err_sync = 0;
  int        err_len = 0;
  int        err_other = 0;

  linemult_top u_dut (
    .VCLK_o        (VCLK_o),
    .nVRST_o       (nVRST_o),
    .vdata_valid_i (vdata_valid_i),
    .nhsync_i      (nhsync_i),
    .nvsync_i      (nvsync_i),
    .r_i           (r_i),
    .g_i           (g_i),
    .b_i           (b_i),
    .sl_en_i       (sl_en_i),
    .sl_id_i       (sl_id_i),
    .sl_str_i      (sl_str_i),
    .vdata_valid_o (vdata_valid_o),
    .nhsync_o      (nhsync_o),
    .nvsync_o      (nvsync_o),
    .r_o           (r_o),
    .g_o           (g_o),
    .b_o           (b_o)
  );

  always #(CLK_PERIOD / 2) VCLK_o = ~VCLK_o;

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return s[0] ? ({1'b0, s[15:1]} ^ 16'hB400) : {1'b0, s[15:1]};
  endfunction

  task automatic take_bits(input int n, output color_in_t v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v          = {v[COLOR_W_IN-2:0], lfsr_state[0]};  // one step per bit
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // 7 to 8 bit expansion, then optional darkening
  function automatic color_out_t expect_chan(color_in_t c, logic dark, sl_str_t str);
    int full;
    int scaled;
    full   = (int'(c) << 1) | (int'(c) >> 6);
    scaled = (full * (255 - int'(str))) / 256;
    return dark ? color_out_t'(scaled) : color_out_t'(full);
  endfunction

  task automatic check_color(input string name, input color_out_t got, input color_out_t want);
    if (got !== want) begin
      err_color++;
      $display("FAIL time=%0t %s got=%0h expected=%0h", $time, name, got, want);
    end
  endtask

  task automatic check_sync(input string name, input logic got, input logic want);
    if (got !== want) begin
      err_sync++;
      $display("FAIL time=%0t %s got=%b expected=%b", $time, name, got, want);
    end
  endtask

  task automatic check_len(input string name, input hcnt_t got, input hcnt_t want);
    if (got !== want) begin
      err_len++;
      $display("FAIL time=%0t %s got=%0d expected=%0d", $time, name, got, want);
    end
  endtask

  task automatic load_patterns(output logic ok);
    int    fd;
    int    n;
    string text;
    int    len;
    int    vs;
    int    en;
    int    id;
    int    str;
    ok = 1'b0;
    fd = $fopen("bench/linemult_patterns.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        text = "";
        n    = $fgets(text, fd);
        if (n > 0 && text.len() > 0 && text[0] != "#") begin
          if ($sscanf(text, "%d %d %d %d %d", len, vs, en, id, str) == 5
              && num_rec < MAX_REC) begin
            rec_len[num_rec] = len;
            rec_vs[num_rec]  = (vs != 0);
            rec_en[num_rec]  = (en != 0);
            rec_id[num_rec]  = (id != 0);
            rec_str[num_rec] = sl_str_t'(str);
            total_strobes   += len;
            if (len <= int'(LINE_LEN_MAX))
              exp_accept++;
            num_rec++;
          end
        end
      end
      $fclose(fd);
      ok = (num_rec > 0);
    end
  endtask

  // one input line, strobe on every second clock
  task automatic drive_line(input int idx);
    int        p;
    color_in_t cr;
    color_in_t cg;
    color_in_t cb;
    for (p = 0; p < rec_len[idx]; p++) begin
      @(posedge VCLK_o);
      #2;
      take_bits(COLOR_W_IN, cr);
      take_bits(COLOR_W_IN, cg);
      take_bits(COLOR_W_IN, cb);
      vdata_valid_i = 1'b1;
      nhsync_i      = (p >= IN_HS_WIDTH);
      nvsync_i      = rec_vs[idx];
      r_i           = cr;
      g_i           = cg;
      b_i           = cb;
      if (p == rec_len[idx] / 2) begin  // settings change mid line
        sl_en_i  = rec_en[idx];
        sl_id_i  = rec_id[idx];
        sl_str_i = rec_str[idx];
      end
      @(posedge VCLK_o);
      #2 vdata_valid_i = 1'b0;
    end
  endtask

  // a final line start closes the last record
  task automatic close_last_line();
    @(posedge VCLK_o);
    #2;
    vdata_valid_i = 1'b1;
    nhsync_i      = 1'b0;
    @(posedge VCLK_o);
    #2 vdata_valid_i = 1'b0;
    repeat (2) @(posedge VCLK_o);
  endtask

  task automatic check_pixel();
    int         li;
    int         cp;
    int         a;
    logic       act;
    logic       dark;
    color_out_t er;
    color_out_t eg;
    color_out_t eb;
    li = out_lines / 2;
    cp = out_lines % 2;
    if (li >= start_cnt) begin
      if (extra_reported != out_lines) begin
        extra_reported = out_lines;
        err_other++;
        $display("output line %0d has no matching input line", out_lines);
      end
    end else begin
      act  = out_pos >= int'(HSTART) && out_pos < int'(HSTOP) && out_pos < int'(exp_len[li]);
      dark = exp_sl_en[li] && (cp == int'(exp_sl_id[li]));
      er   = '0;
      eg   = '0;
      eb   = '0;
      if (act) begin
        a  = out_pos - int'(HSTART);
        er = expect_chan(exp_r[li][a], dark, exp_sl_str[li]);
        eg = expect_chan(exp_g[li][a], dark, exp_sl_str[li]);
        eb = expect_chan(exp_b[li][a], dark, exp_sl_str[li]);
      end
      check_color("r_o", r_o, er);
      check_color("g_o", g_o, eg);
      check_color("b_o", b_o, eb);
      check_sync("nhsync_o", nhsync_o, out_pos >= int'(HS_WIDTH));
      check_sync("nvsync_o", nvsync_o, exp_vs[li]);
    end
  endtask

  task automatic finish_line();
    int li;
    li = out_lines / 2;
    if (li < start_cnt)
      check_len("nhsync_o period", hcnt_t'(out_pos), exp_len[li]);
    out_lines = out_lines + 1;
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////

  always @(posedge VCLK_o) begin
    cyc = cyc + 1;
    // playback of the oldest waiting line once the last pair is over
    if (start_cnt < ann_cnt && cyc > ann_edge[start_cnt] && cyc >= free_edge) begin
      exp_sl_en[start_cnt]  = sl_en_i;
      exp_sl_id[start_cnt]  = sl_id_i;
      exp_sl_str[start_cnt] = sl_str_i;
      free_edge             = cyc + 2 * int'(exp_len[start_cnt]);
      start_cnt             = start_cnt + 1;
    end
    if (ann_cnt - start_cnt > 1 && !backlog_seen) begin
      backlog_seen = 1'b1;
      err_other++;
      $display("more than one completed line is waiting for playback");
    end
    if (nVRST_o && vdata_valid_i) begin
      if (model_hs_prev && !nhsync_i) begin
        if (model_in_line && line_cnt <= int'(LINE_LEN_MAX) && ann_cnt < MAX_LINES - 1) begin
          exp_len[ann_cnt]  = hcnt_t'(line_cnt);
          ann_edge[ann_cnt] = cyc;
          ann_cnt           = ann_cnt + 1;
        end
        model_in_line   = 1'b1;
        line_cnt        = 1;
        exp_vs[ann_cnt] = nvsync_i;  // vsync at position 0
      end else if (model_in_line) begin
        if (line_cnt >= int'(HSTART) && line_cnt < int'(HSTOP)) begin
          exp_r[ann_cnt][line_cnt - int'(HSTART)] = r_i;
          exp_g[ann_cnt][line_cnt - int'(HSTART)] = g_i;
          exp_b[ann_cnt][line_cnt - int'(HSTART)] = b_i;
        end
        line_cnt = line_cnt + 1;
      end
      model_hs_prev = nhsync_i;
    end
  end

  //////////////////////////////
  // output monitor
  //////////////////////////////

  always @(negedge VCLK_o) begin
    if (ann_cnt == 0) begin  // nothing may come out yet
      check_sync("vdata_valid_o", vdata_valid_o, 1'b0);
      check_sync("nhsync_o", nhsync_o, 1'b1);
      check_sync("nvsync_o", nvsync_o, 1'b1);
      check_color("r_o", r_o, '0);
      check_color("g_o", g_o, '0);
      check_color("b_o", b_o, '0);
    end
    if (vdata_valid_o === 1'b1) begin
      if (mon_nhs_prev === 1'b1 && nhsync_o === 1'b0) begin
        if (in_out)
          finish_line();
        in_out  = 1'b1;
        out_pos = 0;
      end
      if (in_out) begin
        check_pixel();
        out_pos = out_pos + 1;
      end else if (!stray_seen) begin
        stray_seen = 1'b1;
        err_other++;
        $display("output valid went high without an hsync pulse");
      end
    end else if (in_out) begin
      finish_line();
      in_out = 1'b0;
    end
    mon_nhs_prev = nhsync_o;
  end

  //////////////////////////////
  // main flow and watchdog
  //////////////////////////////

  initial begin
    VCLK_o        = 1'b0;
    nVRST_o       = 1'b0;
    vdata_valid_i = 1'b0;
    nhsync_i      = 1'b1;
    nvsync_i      = 1'b1;
    r_i           = '0;
    g_i           = '0;
    b_i           = '0;
    sl_en_i       = 1'b0;
    sl_id_i       = 1'b0;
    sl_str_i      = '0;
    lfsr_state    = 16'd18558;
    load_patterns(load_ok);
    if (!load_ok) begin
      $display("pattern file is missing or holds no records");
      $display("RESULT: FAIL");
      $finish;
    end else begin
      patterns_loaded = 1'b1;
      repeat (5) @(posedge VCLK_o);
      #2 nVRST_o = 1'b1;
      repeat (4) @(posedge VCLK_o);
      for (int i = 0; i < num_rec; i++)
        drive_line(i);
      close_last_line();
      wait (out_lines >= 2 * ann_cnt && !in_out);
      repeat (20) @(posedge VCLK_o);  // catch any trailing output line
      if (out_lines != 2 * exp_accept) begin
        err_other++;
        $display("saw %0d output lines, but the file has %0d lines within the limit",
                 out_lines, exp_accept);
      end
      if (out_lines != 2 * ann_cnt) begin
        err_other++;
        $display("saw %0d output lines for %0d input lines", out_lines, ann_cnt);
      end
      $display("errors: %0d color, %0d sync, %0d length, %0d other",
               err_color, err_sync, err_len, err_other);
      if (err_color + err_sync + err_len + err_other == 0)
        $display("RESULT: PASS");
      else
        $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    wait (patterns_loaded === 1'b1);
    #((4 * total_strobes + 200) * CLK_PERIOD);  // two clocks per strobe, twice over
    $display("watchdog expired with %0d of %0d output lines seen", out_lines, 2 * ann_cnt);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* bench/linemult_patterns.txt */
# columns: line length in strobes, nvsync level, sl_en, sl_id, sl_str (all decimal)
# lines longer than 200 strobes are dropped by the DUT
64 1 0 0 0
64 1 1 1 128
70 0 1 0 0
60 0 1 1 255
210 1 1 0 64
64 1 1 0 200
40 1 0 0 0
64 1 1 1 96
58 1 0 1 255
200 0 1 1 32

/* all.f */
design/video_pkg.sv
design/linemult_pkg.sv
design/linemult_if.sv
design/line_writer.sv
design/line_buffer.sv
design/line_reader.sv
design/scanline_gen.sv
design/linemult_top.sv
bench/tb_linemult.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_linemult -Mdir obj_dir \
  > build.log 2>&1 \
  || { echo "verilator build failed, see build.log"; exit 1; }

./obj_dir/Vtb_linemult > sim.log 2>&1 \
  && grep -q "RESULT: PASS" sim.log \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed, see sim.log"; exit 1; }
